// File: mem_test.f
mem_test_pkg.sv
mem_test_index.sv
mem_test_fsm.sv
mem_test_checker.sv
axi_sram_controller.sv
mem_test_top.sv
tb_clock_gen.sv
sram_model.sv
mem_test_tb.sv

// File: mem_test_tb.sv
`timescale 1ns/1ps

module mem_test_tb import mem_test_pkg::*; ();

  localparam int NUM_RUNS    = 12;
  localparam int WORST_CYCLES = SRAM_ACCESS_CYCLES + 4;  // Issue, accept, access, response
  localparam int TIMEOUT_CYCLES = NUM_RUNS * (NUM_WORDS * 2 * WORST_CYCLES + 20) + 100;
  localparam int BIT_SEL     = $clog2(DATA_BITS);

  logic                 clk;
  logic                 reset;
  logic                 start;
  logic [ADDR_BITS-1:0] base_addr;
  logic [DATA_BITS-1:0] pattern_base;
  logic                 test_done;
  logic                 test_pass;
  logic [IDX_BITS-1:0]  fail_index;
  logic [ADDR_BITS-1:0] sram_addr;
  wire  [DATA_BITS-1:0] sram_data;
  logic                 sram_we_n;
  logic                 sram_oe_n;
  logic                 sram_ce_n;

  logic                 fault_en;
  logic [ADDR_BITS-1:0] fault_addr;
  logic [BIT_SEL-1:0]   fault_bit;
  logic                 fault_val;
  logic                 idle_watch;
  integer               seed = 32'h3a07;
  int                   mismatch_errors = 0;
  int                   other_errors = 0;
  int                   cycle_count = 0;

  tb_clock_gen u_clk (.clk(clk));

  mem_test_top u_dut (
    .clk(clk), .reset(reset), .start(start),
    .base_addr(base_addr), .pattern_base(pattern_base),
    .test_done(test_done), .test_pass(test_pass), .fail_index(fail_index),
    .sram_addr(sram_addr), .sram_data(sram_data),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

  sram_model u_sram (
    .addr(sram_addr), .data(sram_data),
    .we_n(sram_we_n), .oe_n(sram_oe_n), .ce_n(sram_ce_n),
    .fault_en(fault_en), .fault_addr(fault_addr),
    .fault_bit(fault_bit), .fault_val(fault_val)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      mismatch_errors++;
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_counts();
    $display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
  endtask

  // Word i holds pattern + i unless the stuck bit changes it
  task automatic predict_result(input logic [ADDR_BITS-1:0] base,
                                input logic [DATA_BITS-1:0] pattern,
                                output logic pass, output logic [IDX_BITS-1:0] index);
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] word;
    logic [DATA_BITS-1:0] seen;
    pass  = 1'b1;
    index = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr = base + ADDR_BITS'(i);
      word = pattern + DATA_BITS'(i);
      seen = word;
      if (fault_en && (addr == fault_addr)) begin
        seen[fault_bit] = fault_val;
      end
      if (pass && (seen != word)) begin
        pass  = 1'b0;
        index = IDX_BITS'(i);
      end
    end
  endtask

  task automatic check_memory(input logic [ADDR_BITS-1:0] base,
                              input logic [DATA_BITS-1:0] pattern);
    logic [ADDR_BITS-1:0] addr;
    logic [DATA_BITS-1:0] word;
    for (int i = 0; i < NUM_WORDS; i++) begin
      addr = base + ADDR_BITS'(i);
      word = pattern + DATA_BITS'(i);  // Wraps at the data width
      check_value($sformatf("sram mem[%h]", addr), u_sram.mem[addr], word);
    end
  endtask

  // Entered and left on a falling edge
  task automatic run_test(input int r);
    logic [ADDR_BITS-1:0] base;
    logic [DATA_BITS-1:0] pattern;
    logic                 exp_pass;
    logic [IDX_BITS-1:0]  exp_idx;
    int                   fault_word;
    bit                   interfere;
    bit                   back_to_back;
    base         = ADDR_BITS'($random(seed));
    pattern      = DATA_BITS'($random(seed));
    interfere    = (r % 4 == 2);
    back_to_back = (r % 4 == 3);
    fault_word   = $unsigned($random(seed)) % NUM_WORDS;
    fault_en     = (r % 3 == 1);
    fault_addr   = base + ADDR_BITS'(fault_word);
    fault_bit    = BIT_SEL'($random(seed));
    fault_val    = 1'($random(seed));
    if (!back_to_back) begin
      repeat (6) @(negedge clk);  // Let stale reads of a failed run drain
      idle_watch <= 1'b1;
      repeat (1 + $unsigned($random(seed)) % 4) @(negedge clk);
      idle_watch <= 1'b0;
    end
    base_addr    = base;
    pattern_base = pattern;
    start        = 1'b1;
    @(negedge clk);
    start        = 1'b0;
    base_addr    = ADDR_BITS'($random(seed));  // Origin must already be latched
    pattern_base = DATA_BITS'($random(seed));
    check_value("test_done", test_done, 0);
    if (interfere) begin
      repeat (4) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (test_done !== 1'b1) @(negedge clk);
    predict_result(base, pattern, exp_pass, exp_idx);
    check_value("test_pass", test_pass, exp_pass);
    if (!exp_pass) begin
      check_value("fail_index", fail_index, exp_idx);
    end
    check_memory(base, pattern);
    $display("run %0d: base %h pattern %h fault %0b -> pass %0b", r, base, pattern,
             fault_en, test_pass);
  endtask

  // SRAM pin watch
  always @(negedge clk) begin
    if (!reset) begin
      assert (!(sram_we_n === 1'b0 && sram_oe_n === 1'b0)) else begin
        other_errors++;
        $display("write enable and output enable both low at %0t", $time);
      end
      if (idle_watch) begin
        assert (sram_we_n === 1'b1 && sram_oe_n === 1'b1 && sram_ce_n === 1'b1) else begin
          other_errors++;
          $display("SRAM control pins active while the tester is idle at %0t", $time);
        end
      end
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    other_errors++;
    $display("timeout after %0d cycles, test_done never came", TIMEOUT_CYCLES);
    report_counts();
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    reset        = 1'b1;
    start        = 1'b0;
    base_addr    = '0;
    pattern_base = '0;
    fault_en     = 1'b0;
    fault_addr   = '0;
    fault_bit    = '0;
    fault_val    = 1'b0;
    idle_watch   = 1'b0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_value("test_done", test_done, 0);
    check_value("test_pass", test_pass, 1);
    check_value("sram_we_n", sram_we_n, 1);
    check_value("sram_oe_n", sram_oe_n, 1);
    check_value("sram_ce_n", sram_ce_n, 1);
    assert (sram_data === 'z) else begin
      other_errors++;
      $display("SRAM data bus driven after reset");
    end
    for (int r = 0; r < NUM_RUNS; r++) begin
      run_test(r);
    end
    report_counts();
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sram_model.sv
`timescale 1ns/1ps

module sram_model import mem_test_pkg::*; (
  input  logic                         [ADDR_BITS-1:0] addr,
  inout  wire                          [DATA_BITS-1:0] data,
  input  logic                                         we_n,
  input  logic                                         oe_n,
  input  logic                                         ce_n,
  input  logic                                         fault_en,
  input  logic                         [ADDR_BITS-1:0] fault_addr,
  input  logic [$clog2(DATA_BITS)-1:0]                 fault_bit,
  input  logic                                         fault_val
);

  logic [DATA_BITS-1:0] mem [0:(1 << ADDR_BITS)-1];
  logic [DATA_BITS-1:0] raw_word;
  logic [DATA_BITS-1:0] rd_word;
  logic [DATA_BITS-1:0] fault_mask;
  logic                 fault_hit;
  logic                 read_en;

  // Level-sensitive write while CE and WE are both low
  always @(we_n or ce_n or addr or data) begin
    if (!ce_n && !we_n) begin
      mem[addr] = data;
    end
  end

  assign raw_word   = mem[addr];
  assign fault_mask = DATA_BITS'(1) << fault_bit;
  assign fault_hit  = fault_en && (addr == fault_addr);  // Stuck cell seen on reads only

  assign rd_word = !fault_hit ? raw_word :
                   fault_val  ? (raw_word | fault_mask) : (raw_word & ~fault_mask);

  assign read_en = !ce_n && !oe_n && we_n;
  assign data    = read_en ? rd_word : 'z;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  localparam time HALF_PERIOD = 4ns;  // 8 ns period

  initial begin
    clk = 1'b0;
  end

  always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: mem_test_top.sv
`timescale 1ns/1ps

module mem_test_top import mem_test_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [ADDR_BITS-1:0] base_addr,
  input  logic [DATA_BITS-1:0] pattern_base,
  output logic                 test_done,
  output logic                 test_pass,
  output logic [IDX_BITS-1:0]  fail_index,
  output logic [ADDR_BITS-1:0] sram_addr,
  inout  wire  [DATA_BITS-1:0] sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  test_state_t          state;
  logic                 start_accept;
  logic                 wr_fire;
  logic                 ar_fire;
  logic                 r_fire;
  logic [IDX_BITS-1:0]  wr_idx;
  logic [IDX_BITS-1:0]  ar_idx;
  logic [IDX_BITS-1:0]  rd_idx;
  logic                 wr_last;
  logic                 ar_all;
  logic                 rd_last;
  logic                 data_ok;

  logic [ADDR_BITS-1:0] axi_awaddr;
  logic                 axi_awvalid;
  logic                 axi_awready;
  logic [DATA_BITS-1:0] axi_wdata;
  logic [STRB_BITS-1:0] axi_wstrb;
  logic                 axi_wvalid;
  logic                 axi_wready;
  logic                 axi_bvalid;
  logic                 axi_bready;
  logic [ADDR_BITS-1:0] axi_araddr;
  logic                 axi_arvalid;
  logic                 axi_arready;
  logic [DATA_BITS-1:0] axi_rdata;
  logic                 axi_rvalid;
  logic                 axi_rready;

  // Origin only moves when the FSM will actually restart
  assign start_accept = start && (state != ST_WRITE) && (state != ST_READ);

  mem_test_fsm u_fsm (
    .clk(clk), .reset(reset), .start(start),
    .wr_last(wr_last), .ar_all(ar_all), .rd_last(rd_last), .data_ok(data_ok),
    .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
    .axi_wvalid(axi_wvalid), .axi_wready(axi_wready), .axi_bvalid(axi_bvalid),
    .axi_arvalid(axi_arvalid), .axi_arready(axi_arready), .axi_rvalid(axi_rvalid),
    .axi_bready(axi_bready), .axi_rready(axi_rready),
    .wr_fire(wr_fire), .ar_fire(ar_fire), .r_fire(r_fire),
    .state(state), .test_done(test_done), .test_pass(test_pass)
  );

  mem_test_index u_index (
    .clk(clk), .reset(reset), .state(state),
    .wr_fire(wr_fire), .ar_fire(ar_fire), .r_fire(r_fire),
    .wr_idx(wr_idx), .ar_idx(ar_idx), .rd_idx(rd_idx),
    .wr_last(wr_last), .ar_all(ar_all), .rd_last(rd_last)
  );

  // Stale responses after a failed test never reach the fail capture
  mem_test_checker u_checker (
    .clk(clk), .reset(reset), .start(start_accept),
    .base_addr(base_addr), .pattern_base(pattern_base),
    .wr_idx(wr_idx), .ar_idx(ar_idx), .rd_idx(rd_idx),
    .axi_awaddr(axi_awaddr), .axi_wdata(axi_wdata), .axi_araddr(axi_araddr),
    .axi_wstrb(axi_wstrb), .axi_rdata(axi_rdata), .axi_rvalid(r_fire),
    .data_ok(data_ok), .fail_index(fail_index)
  );

  axi_sram_controller u_ctrl (
    .clk(clk), .reset(reset),
    .axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
    .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
    .axi_wvalid(axi_wvalid), .axi_wready(axi_wready),
    .axi_bresp(), .axi_bvalid(axi_bvalid), .axi_bready(axi_bready),  // Always OKAY
    .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
    .axi_rdata(axi_rdata), .axi_rresp(), .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
    .sram_addr(sram_addr), .sram_data(sram_data),
    .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n), .sram_ce_n(sram_ce_n)
  );

endmodule

// File: axi_sram_controller.sv
`timescale 1ns/1ps

module axi_sram_controller import mem_test_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [ADDR_BITS-1:0] axi_awaddr,
  input  logic                 axi_awvalid,
  output logic                 axi_awready,
  input  logic [DATA_BITS-1:0] axi_wdata,
  input  logic [STRB_BITS-1:0] axi_wstrb,
  input  logic                 axi_wvalid,
  output logic                 axi_wready,
  output logic [1:0]           axi_bresp,
  output logic                 axi_bvalid,
  input  logic                 axi_bready,
  input  logic [ADDR_BITS-1:0] axi_araddr,
  input  logic                 axi_arvalid,
  output logic                 axi_arready,
  output logic [DATA_BITS-1:0] axi_rdata,
  output logic [1:0]           axi_rresp,
  output logic                 axi_rvalid,
  input  logic                 axi_rready,
  output logic [ADDR_BITS-1:0] sram_addr,
  inout  wire  [DATA_BITS-1:0] sram_data,
  output logic                 sram_we_n,
  output logic                 sram_oe_n,
  output logic                 sram_ce_n
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_WRITE,
    C_READ,
    C_RESP
  } ctrl_state_t;

  ctrl_state_t           state;
  logic [TIMER_BITS-1:0] timer;
  logic [DATA_BITS-1:0]  wdata_q;
  logic                  drive_en;
  logic                  wr_accept;
  logic                  rd_accept;
  logic                  access_end;

  // Address and data are taken in the same cycle; writes win over reads
  assign wr_accept   = (state == C_IDLE) && axi_awvalid && axi_wvalid;
  assign rd_accept   = (state == C_IDLE) && axi_arvalid && !wr_accept;
  assign axi_awready = wr_accept;
  assign axi_wready  = wr_accept;
  assign axi_arready = rd_accept;

  assign access_end = (timer == TIMER_BITS'(SRAM_ACCESS_CYCLES - 1));

  assign axi_bresp = RESP_OKAY;
  assign axi_rresp = RESP_OKAY;

  assign sram_data = drive_en ? wdata_q : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= C_IDLE;
      timer      <= '0;
      sram_we_n  <= 1'b1;
      sram_oe_n  <= 1'b1;
      sram_ce_n  <= 1'b1;
      drive_en   <= 1'b0;
      axi_bvalid <= 1'b0;
      axi_rvalid <= 1'b0;
    end else begin
      case (state)
        C_IDLE: begin
          timer <= '0;
          if (wr_accept) begin
            state     <= C_WRITE;
            sram_ce_n <= 1'b0;
            sram_we_n <= ~&axi_wstrb;  // Partial strobes answered but not written
            drive_en  <= 1'b1;
          end else if (rd_accept) begin
            state     <= C_READ;
            sram_ce_n <= 1'b0;
            sram_oe_n <= 1'b0;
          end
        end
        C_WRITE: begin
          timer <= timer + 1'b1;
          if (access_end) begin
            state      <= C_RESP;
            sram_we_n  <= 1'b1;  // SRAM latches on this rising edge
            sram_ce_n  <= 1'b1;
            axi_bvalid <= 1'b1;
          end
        end
        C_READ: begin
          timer <= timer + 1'b1;
          if (access_end) begin
            state      <= C_RESP;
            sram_oe_n  <= 1'b1;
            sram_ce_n  <= 1'b1;
            axi_rvalid <= 1'b1;
          end
        end
        C_RESP: begin
          // Stall here until the response is taken
          if ((axi_bvalid && axi_bready) || (axi_rvalid && axi_rready)) begin
            state      <= C_IDLE;
            axi_bvalid <= 1'b0;
            axi_rvalid <= 1'b0;
            drive_en   <= 1'b0;  // Data held one cycle past WE rising
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      sram_addr <= axi_awaddr;
      wdata_q   <= axi_wdata;
    end else if (rd_accept) begin
      sram_addr <= axi_araddr;
    end
    if ((state == C_READ) && access_end) begin
      axi_rdata <= sram_data;  // Last OE cycle
    end
  end

endmodule

// File: mem_test_checker.sv
`timescale 1ns/1ps

module mem_test_checker import mem_test_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [ADDR_BITS-1:0] base_addr,
  input  logic [DATA_BITS-1:0] pattern_base,
  input  logic [IDX_BITS-1:0]  wr_idx,
  input  logic [IDX_BITS-1:0]  ar_idx,
  input  logic [IDX_BITS-1:0]  rd_idx,
  output logic [ADDR_BITS-1:0] axi_awaddr,
  output logic [DATA_BITS-1:0] axi_wdata,
  output logic [ADDR_BITS-1:0] axi_araddr,
  output logic [STRB_BITS-1:0] axi_wstrb,
  input  logic [DATA_BITS-1:0] axi_rdata,
  input  logic                 axi_rvalid,
  output logic                 data_ok,
  output logic [IDX_BITS-1:0]  fail_index
);

  logic [ADDR_BITS-1:0] base_q;
  logic [DATA_BITS-1:0] pattern_q;
  logic [DATA_BITS-1:0] expected;

  // Test origin
  always_ff @(posedge clk) begin
    if (start) begin
      base_q    <= base_addr;
      pattern_q <= pattern_base;
    end
  end

  // Word i lives at base + i and holds pattern + i
  assign axi_awaddr = base_q + ADDR_BITS'(wr_idx);
  assign axi_wdata  = pattern_q + DATA_BITS'(wr_idx);
  assign axi_araddr = base_q + ADDR_BITS'(ar_idx);
  assign axi_wstrb  = '1;

  assign expected = pattern_q + DATA_BITS'(rd_idx);
  assign data_ok  = (axi_rdata == expected);

  // A mismatch ends the test, so only the first one is ever seen here
  always_ff @(posedge clk) begin
    if (reset || start) begin
      fail_index <= '0;
    end else if (axi_rvalid && !data_ok) begin
      fail_index <= rd_idx;
    end
  end

endmodule

// File: mem_test_fsm.sv
`timescale 1ns/1ps

module mem_test_fsm import mem_test_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        wr_last,
  input  logic        ar_all,
  input  logic        rd_last,
  input  logic        data_ok,
  output logic        axi_awvalid,
  input  logic        axi_awready,
  output logic        axi_wvalid,
  input  logic        axi_wready,
  input  logic        axi_bvalid,
  output logic        axi_arvalid,
  input  logic        axi_arready,
  input  logic        axi_rvalid,
  output logic        axi_bready,
  output logic        axi_rready,
  output logic        wr_fire,
  output logic        ar_fire,
  output logic        r_fire,
  output test_state_t state,
  output logic        test_done,
  output logic        test_pass
);

  test_state_t state_next;
  logic        aw_hs;
  logic        w_hs;
  logic        aw_acc;       // Address channel already taken for this word
  logic        w_acc;        // Data channel already taken for this word
  logic        b_wait;       // Write accepted, response not yet seen
  logic        write_issue;
  logic        read_issue;

  assign axi_bready = 1'b1;
  assign axi_rready = 1'b1;

  assign aw_hs   = axi_awvalid && axi_awready;
  assign w_hs    = axi_wvalid && axi_wready;
  assign wr_fire = (aw_acc || aw_hs) && (w_acc || w_hs);
  assign ar_fire = axi_arvalid && axi_arready;
  assign r_fire  = (state == ST_READ) && axi_rvalid && axi_rready;

  // Next word goes out once the previous one is fully retired
  assign write_issue = (state == ST_WRITE) && !axi_awvalid && !axi_wvalid
                       && !aw_acc && !w_acc && !b_wait;
  assign read_issue  = (state == ST_READ) && !axi_arvalid && !ar_all;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE, ST_DONE, ST_FAIL: begin
        if (start) begin
          state_next = ST_WRITE;
        end
      end
      ST_WRITE: begin
        if (wr_fire && wr_last) begin
          state_next = ST_READ;
        end
      end
      ST_READ: begin
        if (r_fire) begin
          if (!data_ok) begin
            state_next = ST_FAIL;
          end else if (rd_last) begin
            state_next = ST_DONE;
          end
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= ST_IDLE;
      axi_awvalid <= 1'b0;
      axi_wvalid  <= 1'b0;
      axi_arvalid <= 1'b0;
      aw_acc      <= 1'b0;
      w_acc       <= 1'b0;
      b_wait      <= 1'b0;
    end else begin
      state       <= state_next;
      // A raised valid stays up until its ready
      axi_awvalid <= (axi_awvalid && !axi_awready) || write_issue;
      axi_wvalid  <= (axi_wvalid && !axi_wready) || write_issue;
      axi_arvalid <= (axi_arvalid && !axi_arready) || read_issue;
      aw_acc      <= !wr_fire && (aw_acc || aw_hs);
      w_acc       <= !wr_fire && (w_acc || w_hs);
      if (wr_fire) begin
        b_wait <= 1'b1;
      end else if (axi_bvalid && axi_bready) begin
        b_wait <= 1'b0;
      end
    end
  end

  assign test_done = (state == ST_DONE) || (state == ST_FAIL);
  assign test_pass = (state != ST_FAIL);

endmodule

// File: mem_test_index.sv
`timescale 1ns/1ps

module mem_test_index import mem_test_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  test_state_t         state,
  input  logic                wr_fire,
  input  logic                ar_fire,
  input  logic                r_fire,
  output logic [IDX_BITS-1:0] wr_idx,
  output logic [IDX_BITS-1:0] ar_idx,
  output logic [IDX_BITS-1:0] rd_idx,
  output logic                wr_last,
  output logic                ar_all,
  output logic                rd_last
);

  test_state_t state_q;
  logic        clear;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state;
    end
  end

  // Idle, or the first cycle of a new write phase
  assign clear = (state == ST_IDLE) || ((state == ST_WRITE) && (state_q != ST_WRITE));

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      wr_idx <= '0;
      ar_idx <= '0;
      rd_idx <= '0;
    end else begin
      if (wr_fire) begin
        wr_idx <= wr_idx + 1'b1;
      end
      if (ar_fire) begin
        ar_idx <= ar_idx + 1'b1;
      end
      if (r_fire) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  assign wr_last = (wr_idx == IDX_BITS'(NUM_WORDS - 1));
  assign ar_all  = (ar_idx == IDX_BITS'(NUM_WORDS));      // Every address handed out
  assign rd_last = (rd_idx == IDX_BITS'(NUM_WORDS - 1));

endmodule

// File: mem_test_pkg.sv
package mem_test_pkg;

  // SRAM geometry
  localparam int ADDR_BITS = 20;
  localparam int DATA_BITS = 16;
  localparam int STRB_BITS = (DATA_BITS + 7) / 8;

  // Test length and word index width
  localparam int NUM_WORDS = 8;
  localparam int IDX_BITS  = $clog2(NUM_WORDS + 1);  // Must hold NUM_WORDS itself

  // Cycles each SRAM access keeps WE or OE asserted
  localparam int SRAM_ACCESS_CYCLES = 2;
  localparam int TIMER_BITS         = $clog2(SRAM_ACCESS_CYCLES + 1);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Tester sequence
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,  // Issue one write per word
    ST_READ,   // Stream read addresses, check responses
    ST_DONE,
    ST_FAIL
  } test_state_t;

endpackage
